// ==== filelist.f ====
common/predecode_pkg.sv
design/byte_fifo.sv
predecode/length_decoder.sv
predecode/opcode_window.sv
predecode/instr_assembler.sv
design/predecode_top.sv
test/predecode_checker.sv
test/predecode_tb.sv

// ==== test/predecode_tb.sv ====
// predecode_tb, clock, reset, random instruction stream, reference model, scoreboard, timeout
`default_nettype none
`timescale 1ns/1ns

module predecode_tb;

	import predecode_pkg::*;

	localparam int in_depth = 8;
	localparam int out_credits = 4;
	localparam addr_t reset_pc = 16'h0200;
	localparam int seed = 31368;
	localparam int bursts = 8;
	localparam int burst_len = 40;

	typedef struct packed {
		addr_t pc;
		byte_t op;
		operand_t operand;
		len_t len;
		pcinc_t inc;
		logic ill;
	} record_t;

	logic clk, reset, m_bit, x_bit, byte_valid, instr_credit;
	byte_t byte_data;
	logic byte_credit, instr_valid, instr_illegal;
	addr_t instr_pc;
	byte_t instr_opcode;
	operand_t instr_operand;
	len_t instr_len;
	pcinc_t instr_pcinc;

	// opcode pools grouped by the length rule they fall under
	byte_t ops1[$] = '{op_clc, op_sec, op_cli, op_sei, op_clv, op_cld, op_sed, op_tax, op_txa,
		op_tay, op_tya, op_tsx, op_txs, op_txy, op_tyx, op_nop, op_rts, op_rti, op_asl_acc,
		op_lsr_acc, op_rol_acc, op_ror_acc, op_pha, op_pla, op_php, op_plp, op_phx, op_plx,
		op_phy, op_ply};
	byte_t ops2[$] = '{op_brk, op_bpl, op_bmi, op_bvc, op_bvs, op_bcc, op_bcs, op_bne, op_beq,
		op_bra, op_adc_zp, op_adc_zpx, op_adc_i, op_adc_ix, op_adc_iy, op_sbc_zp, op_sbc_zpx,
		op_sbc_i, op_sbc_ix, op_sbc_iy, op_cmp_zp, op_cmp_zpx, op_cmp_i, op_cmp_ix, op_cmp_iy,
		op_and_zp, op_and_zpx, op_and_i, op_and_ix, op_and_iy, op_ora_zp, op_ora_zpx, op_ora_i,
		op_ora_ix, op_ora_iy, op_eor_zp, op_eor_zpx, op_eor_i, op_eor_ix, op_eor_iy, op_lda_zp,
		op_lda_zpx, op_lda_i, op_lda_ix, op_lda_iy, op_sta_zp, op_sta_zpx, op_sta_i, op_sta_ix,
		op_sta_iy, op_ldx_zp, op_ldx_zpy, op_ldy_zp, op_ldy_zpx};
	byte_t ops3[$] = '{op_brl, op_jmp, op_jsr, op_adc_abs, op_adc_absx, op_adc_absy,
		op_sbc_abs, op_sbc_absx, op_sbc_absy, op_cmp_abs, op_cmp_absx, op_cmp_absy, op_and_abs,
		op_and_absx, op_and_absy, op_ora_abs, op_ora_absx, op_ora_absy, op_eor_abs, op_eor_absx,
		op_eor_absy, op_lda_abs, op_lda_absx, op_lda_absy, op_sta_abs, op_sta_absx, op_sta_absy,
		op_ldx_abs, op_ldx_absy, op_ldy_abs, op_ldy_absx};
	byte_t ops4[$] = '{op_jml, op_jsl};
	byte_t imm_a[$] = '{op_adc_imm, op_sbc_imm, op_cmp_imm, op_and_imm, op_ora_imm, op_eor_imm,
		op_lda_imm};
	byte_t imm_xy[$] = '{op_ldx_imm, op_ldy_imm};
	// none of these appear in the opcode table
	byte_t bad_ops[$] = '{8'h02, 8'h03, 8'h42, 8'hcb, 8'hdb, 8'hff};

	byte_t tx_q[$];
	record_t exp_q[$];
	record_t rec;
	addr_t model_pc = reset_pc;
	logic [1:0] mode;
	int cycles = 0, generated = 0, bytes_sent = 0, credits_back = 0;
	int send_credits = in_depth, credits_avail = out_credits, owed = 0, hold = 0;

	predecode_top #(
		.in_depth(in_depth),
		.out_credits(out_credits),
		.reset_pc(reset_pc)
	) predecode_top_inst (
		.clk(clk), .reset(reset), .m_bit(m_bit), .x_bit(x_bit),
		.byte_valid(byte_valid), .byte_data(byte_data), .instr_credit(instr_credit),
		.byte_credit(byte_credit), .instr_valid(instr_valid), .instr_pc(instr_pc),
		.instr_opcode(instr_opcode), .instr_operand(instr_operand), .instr_len(instr_len),
		.instr_pcinc(instr_pcinc), .instr_illegal(instr_illegal)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			stop_run($sformatf("MISMATCH at %0t: %s expected %0h actual %0h",
				$time, name, expected, actual));
	endtask

	// ====================================================================
	// reference model of the length and increment rule
	// ====================================================================

	task automatic make_burst(input logic m, input logic x);
		byte_t op;
		int len;
		pcinc_t inc;
		operand_t opnd;
		logic bad;
		for (int n = 0; n < burst_len; n++) begin
			bad = 1'b0;
			case ($urandom % 7)
				0: begin op = ops1[$urandom % ops1.size()]; len = 1; end
				1: begin op = ops2[$urandom % ops2.size()]; len = 2; end
				2: begin op = ops3[$urandom % ops3.size()]; len = 3; end
				3: begin op = ops4[$urandom % ops4.size()]; len = 4; end
				// immediate width follows m for the accumulator group, x for the index loads
				4: begin op = imm_a[$urandom % imm_a.size()]; len = m ? 2 : 3; end
				5: begin op = imm_xy[$urandom % imm_xy.size()]; len = x ? 2 : 3; end
				default: begin op = bad_ops[$urandom % bad_ops.size()]; len = 1; bad = 1'b1; end
			endcase
			inc = pcinc_t'(len);
			if (bad || op inside {op_brk, op_jmp, op_jml, op_rts, op_rti})
				inc = 4'd0;
			else if (op == op_jsr)
				inc = 4'd2;
			else if (op == op_jsl)
				inc = 4'd4;
			tx_q.push_back(op);
			opnd = '0;
			for (int i = 1; i < len; i++) begin
				opnd[(i - 1) * 8 +: 8] = byte_t'($urandom);
				tx_q.push_back(opnd[(i - 1) * 8 +: 8]);
			end
			exp_q.push_back('{model_pc, op, opnd, len_t'(len), inc, bad});
			model_pc = model_pc + addr_t'(len);
			generated = generated + len;
		end
	endtask

	// every generated byte belongs to a record, so an empty queue means an empty pipeline
	task automatic wait_drained();
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	// sender spends one credit per byte and leaves random gaps
	always @(posedge clk) begin
		if (reset) begin
			byte_valid <= 1'b0;
		end else begin
			if (byte_credit) begin
				send_credits++;
				credits_back++;
			end
			if (tx_q.size() != 0 && send_credits > 0 && $urandom % 4 != 0) begin
				byte_valid <= 1'b1;
				byte_data <= tx_q.pop_front();
				send_credits--;
				bytes_sent++;
			end else begin
				byte_valid <= 1'b0;
			end
		end
	end

	// ====================================================================
	// scoreboard and downstream credit return
	// ====================================================================

	always @(posedge clk) begin
		if (reset) begin
			instr_credit <= 1'b0;
		end else begin
			if (instr_valid) begin
				if (exp_q.size() == 0) begin
					stop_run("an instruction arrived that the model never produced");
				end else begin
					check_value("credit held", 1, credits_avail > 0);
					credits_avail--;
					owed++;
					rec = exp_q.pop_front();
					check_value("instr_pc", rec.pc, instr_pc);
					check_value("instr_opcode", rec.op, instr_opcode);
					check_value("instr_operand", rec.operand, instr_operand);
					check_value("instr_len", rec.len, instr_len);
					check_value("instr_pcinc", rec.inc, instr_pcinc);
					check_value("instr_illegal", rec.ill, instr_illegal);
				end
			end
			// random stretches where downstream keeps its credits
			if (hold > 0)
				hold--;
			else if ($urandom % 8 == 0)
				hold = $urandom % 24;
			if (hold == 0 && owed > 0) begin
				instr_credit <= 1'b1;
				owed--;
				credits_avail++;
			end else begin
				instr_credit <= 1'b0;
			end
		end
	end

	// budget of 40 cycles per generated byte plus room for reset
	always @(posedge clk) begin
		cycles++;
		if (cycles > 40 * generated + 200)
			stop_run("timeout, the stream did not drain in time");
	end

	initial begin
		void'($urandom(seed));
		reset = 1'b1;
		m_bit = 1'b1;
		x_bit = 1'b1;
		byte_valid = 1'b0;
		byte_data = '0;
		instr_credit = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		// two bursts at 8 bit widths, then every m and x combination
		for (int burst = 0; burst < bursts; burst++) begin
			mode = (burst < 2) ? 2'b11 : burst[1:0];
			wait_drained();
			@(posedge clk);
			m_bit <= mode[1];
			x_bit <= mode[0];
			@(negedge clk);
			make_burst(mode[1], mode[0]);
		end
		wait_drained();
		// the credit for the last byte comes back before its instruction can leave
		check_value("byte_credit total", bytes_sent, credits_back);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/predecode_checker.sv ====
// predecode_checker, bound assertions on credit use, fill limits and reset quiet outputs
`default_nettype none
`timescale 1ns/1ns

module predecode_checker #(
	parameter int fill_w = 3,
	parameter int fill_max = 4,
	parameter int grant = 4
) (
	input wire              clk,
	input wire              reset,
	// take spends one credit of the loop and give hands one back
	input wire              take,
	input wire              give,
	input wire [fill_w-1:0] fill,
	// an output pulse that has to stay quiet while reset is held
	input wire              held_low
);

	// starts unknown so the first reset edge is not judged
	logic reset_q;
	// credits the spending side still holds, counted from the loop pulses alone
	int balance;

	always_ff @(posedge clk) begin
		reset_q <= reset;
	end

	always_ff @(posedge clk) begin
		if (reset)
			balance <= grant;
		else
			balance <= balance - int'(take) + int'(give);
	end

	// spending without a credit is a lost byte or an unpaid emission
	take_needs_credit: assert property (@(posedge clk) disable iff (reset)
		take |-> balance > 0)
		else $error("credit spent without one being held");

	fill_in_range: assert property (@(posedge clk) disable iff (reset) fill <= fill_max)
		else $error("occupancy above its limit");

	// from the second reset cycle on the registered pulse must read low
	quiet_in_reset: assert property (@(posedge clk) reset && reset_q |-> !held_low)
		else $error("output pulse during reset");

endmodule

// ====================================================================
// attachments
// ====================================================================

// input side, the sender writes only on a credit and the count never passes the depth
bind byte_fifo predecode_checker #(
	.fill_w(cnt_w),
	.fill_max(in_depth),
	.grant(in_depth)
) fifo_check (
	.clk(clk),
	.reset(reset),
	.take(byte_valid),
	.give(byte_credit),
	.fill(count),
	.held_low(byte_credit)
);

// output side, every valid has to be covered by the initial grant or a returned credit
bind instr_assembler predecode_checker #(
	.fill_w(3),
	.fill_max(predecode_pkg::window_depth),
	.grant(out_credits)
) assembler_check (
	.clk(clk),
	.reset(reset),
	.take(instr_valid),
	.give(instr_credit),
	.fill(win_fill),
	.held_low(instr_valid)
);

`default_nettype wire

// ==== design/predecode_top.sv ====
// predecode_top, input buffer, opcode window, length decoder and instruction assembler
`default_nettype none
`timescale 1ns/1ns

module predecode_top #(
	parameter int                   in_depth = 8,
	parameter int                   out_credits = 4,
	parameter predecode_pkg::addr_t reset_pc = 16'h0200
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        m_bit,
	input  wire                        x_bit,
	input  wire                        byte_valid,
	input  wire predecode_pkg::byte_t  byte_data,
	input  wire                        instr_credit,
	output logic                       byte_credit,
	output logic                       instr_valid,
	output predecode_pkg::addr_t       instr_pc,
	output predecode_pkg::byte_t       instr_opcode,
	output predecode_pkg::operand_t    instr_operand,
	output predecode_pkg::len_t        instr_len,
	output predecode_pkg::pcinc_t      instr_pcinc,
	output logic                       instr_illegal
);

	import predecode_pkg::*;

	// fifo to window handshake
	logic fifo_valid;
	byte_t fifo_data;
	logic fifo_pop;

	// window contents seen by the decoder and the assembler
	byte_t [window_depth-1:0] win_bytes;
	fill_t win_fill;

	// decoder results for the head byte
	len_t dec_len;
	pcinc_t dec_pcinc;
	logic dec_illegal;

	// bytes retired from the window by the assembler
	logic consume;
	len_t consume_len;

	byte_fifo #(
		.in_depth(in_depth)
	) byte_fifo_inst (
		.clk(clk),
		.reset(reset),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.fifo_pop(fifo_pop),
		.byte_credit(byte_credit),
		.fifo_valid(fifo_valid),
		.fifo_data(fifo_data)
	);

	opcode_window opcode_window_inst (
		.clk(clk),
		.reset(reset),
		.fifo_valid(fifo_valid),
		.fifo_data(fifo_data),
		.consume(consume),
		.consume_len(consume_len),
		.fifo_pop(fifo_pop),
		.win_bytes(win_bytes),
		.win_fill(win_fill)
	);

	// only the head of the window is an opcode
	length_decoder length_decoder_inst (
		.opcode(win_bytes[0]),
		.m_bit(m_bit),
		.x_bit(x_bit),
		.dec_len(dec_len),
		.dec_pcinc(dec_pcinc),
		.dec_illegal(dec_illegal)
	);

	instr_assembler #(
		.out_credits(out_credits),
		.reset_pc(reset_pc)
	) instr_assembler_inst (
		.clk(clk),
		.reset(reset),
		.win_bytes(win_bytes),
		.win_fill(win_fill),
		.dec_len(dec_len),
		.dec_pcinc(dec_pcinc),
		.dec_illegal(dec_illegal),
		.instr_credit(instr_credit),
		.consume(consume),
		.consume_len(consume_len),
		.instr_valid(instr_valid),
		.instr_pc(instr_pc),
		.instr_opcode(instr_opcode),
		.instr_operand(instr_operand),
		.instr_len(instr_len),
		.instr_pcinc(instr_pcinc),
		.instr_illegal(instr_illegal)
	);

endmodule

`default_nettype wire

// ==== predecode/instr_assembler.sv ====
// instr_assembler, emits whole instructions under output credits and tracks the address
`default_nettype none
`timescale 1ns/1ns

module instr_assembler #(
	parameter int                   out_credits = 4,
	parameter predecode_pkg::addr_t reset_pc = 16'h0200
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire predecode_pkg::byte_t [predecode_pkg::window_depth-1:0] win_bytes,
	input  wire predecode_pkg::fill_t  win_fill,
	input  wire predecode_pkg::len_t   dec_len,
	input  wire predecode_pkg::pcinc_t dec_pcinc,
	input  wire                        dec_illegal,
	input  wire                        instr_credit,
	output logic                       consume,
	output predecode_pkg::len_t        consume_len,
	output logic                       instr_valid,
	output predecode_pkg::addr_t       instr_pc,
	output predecode_pkg::byte_t       instr_opcode,
	output predecode_pkg::operand_t    instr_operand,
	output predecode_pkg::len_t        instr_len,
	output predecode_pkg::pcinc_t      instr_pcinc,
	output logic                       instr_illegal
);

	import predecode_pkg::*;

	// the counter never holds more than the initial grant
	localparam int credit_w = (out_credits > 1) ? $clog2(out_credits + 1) : 1;

	logic [credit_w-1:0] credit_cnt;
	addr_t pc_q;
	logic emit;
	operand_t operand;

	// an instruction is whole once the window holds all of its bytes
	assign emit = (win_fill >= dec_len) && (credit_cnt != '0);
	// the window drops the emitted bytes in the same cycle
	assign consume = emit;
	assign consume_len = dec_len;

	// operand bytes beyond the instruction length stay zero
	always_comb begin
		operand = '0;
		for (int i = 1; i < window_depth; i++) begin
			if (i < dec_len)
				operand[(i - 1) * 8 +: 8] = win_bytes[i];
		end
	end

	// ====================================================================
	// credits, address and valid
	// ====================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			credit_cnt <= credit_w'(out_credits);
			pc_q <= reset_pc;
			instr_valid <= 1'b0;
		end else begin
			// spend on emit and refill on each returned credit, both may happen at once
			credit_cnt <= credit_cnt - credit_w'(emit) + credit_w'(instr_credit);
			// the address walks the byte stream, not the pc increment
			if (emit)
				pc_q <= pc_q + addr_t'(dec_len);
			instr_valid <= emit;
		end
	end

	// record fields only change on an emission and are read with instr_valid
	always_ff @(posedge clk) begin
		if (emit) begin
			instr_pc <= pc_q;
			instr_opcode <= win_bytes[0];
			instr_operand <= operand;
			instr_len <= dec_len;
			instr_pcinc <= dec_pcinc;
			instr_illegal <= dec_illegal;
		end
	end

endmodule

`default_nettype wire

// ==== predecode/opcode_window.sv ====
// opcode_window, four byte shift window holding the oldest unconsumed stream bytes
`default_nettype none
`timescale 1ns/1ns

module opcode_window (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        fifo_valid,
	input  wire predecode_pkg::byte_t  fifo_data,
	input  wire                        consume,
	input  wire predecode_pkg::len_t   consume_len,
	output logic                       fifo_pop,
	output predecode_pkg::byte_t [predecode_pkg::window_depth-1:0] win_bytes,
	output predecode_pkg::fill_t       win_fill
);

	import predecode_pkg::*;

	// slot 0 is always the oldest byte, so it holds the next opcode
	byte_t [window_depth-1:0] win_q;
	byte_t [window_depth-1:0] shifted;
	fill_t fill_q;
	fill_t shift;
	fill_t keep;

	assign win_bytes = win_q;
	assign win_fill = fill_q;

	// ====================================================================
	// shift and refill decision
	// ====================================================================

	always_comb begin
		// the assembler never consumes more than the window holds
		shift = consume ? fill_t'(consume_len) : '0;
		keep = fill_q - shift;
		// pull a new byte only if a slot is free once this cycle's shift is done
		fifo_pop = fifo_valid && (keep < window_depth);
	end

	// survivors move down to slot 0, vacated upper slots read as zero
	always_comb begin
		for (int i = 0; i < window_depth; i++) begin
			if (i + shift < window_depth)
				shifted[i] = win_q[i + shift];
			else
				shifted[i] = '0;
		end
	end

	// ====================================================================
	// state
	// ====================================================================

	always_ff @(posedge clk) begin
		if (reset)
			fill_q <= '0;
		else
			fill_q <= keep + fill_t'(fifo_pop);
	end

	// the new byte lands right behind the surviving bytes
	always_ff @(posedge clk) begin
		win_q <= shifted;
		if (fifo_pop)
			win_q[keep] <= fifo_data;
	end

endmodule

`default_nettype wire

// ==== predecode/length_decoder.sv ====
// length_decoder, opcode table giving byte length, pc increment and illegal flag
`default_nettype none
`timescale 1ns/1ns

module length_decoder (
	input  wire predecode_pkg::byte_t  opcode,
	input  wire                        m_bit,
	input  wire                        x_bit,
	output predecode_pkg::len_t        dec_len,
	output predecode_pkg::pcinc_t      dec_pcinc,
	output logic                       dec_illegal
);

	import predecode_pkg::*;

	// ====================================================================
	// byte length per opcode
	// ====================================================================

	always_comb begin
		dec_len = len_implied;
		dec_illegal = 1'b0;
		case (opcode)
			// implied, accumulator and stack ops are a lone opcode byte
			op_clc, op_sec, op_cli, op_sei, op_clv, op_cld, op_sed,
			op_tax, op_txa, op_tay, op_tya, op_tsx, op_txs, op_txy, op_tyx,
			op_nop, op_rts, op_rti,
			op_asl_acc, op_lsr_acc, op_rol_acc, op_ror_acc,
			op_pha, op_pla, op_php, op_plp, op_phx, op_plx, op_phy, op_ply:
				dec_len = len_implied;

			// brk carries a signature byte and branches an 8 bit displacement
			op_brk, op_bpl, op_bmi, op_bvc, op_bvs, op_bcc, op_bcs, op_bne, op_beq, op_bra:
				dec_len = len_short;

			// direct page, direct page indexed and indirect forms
			op_adc_zp, op_adc_zpx, op_adc_i, op_adc_ix, op_adc_iy,
			op_sbc_zp, op_sbc_zpx, op_sbc_i, op_sbc_ix, op_sbc_iy,
			op_cmp_zp, op_cmp_zpx, op_cmp_i, op_cmp_ix, op_cmp_iy,
			op_and_zp, op_and_zpx, op_and_i, op_and_ix, op_and_iy,
			op_ora_zp, op_ora_zpx, op_ora_i, op_ora_ix, op_ora_iy,
			op_eor_zp, op_eor_zpx, op_eor_i, op_eor_ix, op_eor_iy,
			op_lda_zp, op_lda_zpx, op_lda_i, op_lda_ix, op_lda_iy,
			op_sta_zp, op_sta_zpx, op_sta_i, op_sta_ix, op_sta_iy,
			op_ldx_zp, op_ldx_zpy, op_ldy_zp, op_ldy_zpx:
				dec_len = len_short;

			// absolute forms, long branch and the 16 bit jumps
			op_brl, op_jmp, op_jsr,
			op_adc_abs, op_adc_absx, op_adc_absy, op_sbc_abs, op_sbc_absx, op_sbc_absy,
			op_cmp_abs, op_cmp_absx, op_cmp_absy, op_and_abs, op_and_absx, op_and_absy,
			op_ora_abs, op_ora_absx, op_ora_absy, op_eor_abs, op_eor_absx, op_eor_absy,
			op_lda_abs, op_lda_absx, op_lda_absy, op_sta_abs, op_sta_absx, op_sta_absy,
			op_ldx_abs, op_ldx_absy, op_ldy_abs, op_ldy_absx:
				dec_len = len_long;

			// 24 bit jumps need a bank byte as well
			op_jml, op_jsl:
				dec_len = len_far;

			// accumulator immediates follow the memory width bit
			op_adc_imm, op_sbc_imm, op_cmp_imm, op_and_imm, op_ora_imm, op_eor_imm,
			op_lda_imm:
				dec_len = m_bit ? len_short : len_long;

			// index immediates follow the index width bit
			op_ldx_imm, op_ldy_imm:
				dec_len = x_bit ? len_short : len_long;

			// anything else is consumed as a single byte and flagged
			default: begin
				dec_len = len_implied;
				dec_illegal = 1'b1;
			end
		endcase
	end

	// ====================================================================
	// pc increment
	// ====================================================================

	// control transfers leave the pc to the execute stage, so most steps are zero
	always_comb begin
		case (opcode)
			op_brk, op_jmp, op_jml, op_rts, op_rti:
				dec_pcinc = 4'd0;
			// jsr pushes the address of its last byte
			op_jsr:
				dec_pcinc = 4'd2;
			op_jsl:
				dec_pcinc = 4'd4;
			// an unimplemented opcode does not move the pc at all
			default:
				dec_pcinc = dec_illegal ? 4'd0 : pcinc_t'(dec_len);
		endcase
	end

endmodule

`default_nettype wire

// ==== design/byte_fifo.sv ====
// byte_fifo, circular input byte buffer that hands back one credit per freed slot
`default_nettype none
`timescale 1ns/1ns

module byte_fifo #(
	parameter int in_depth = 8
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        byte_valid,
	input  wire predecode_pkg::byte_t  byte_data,
	input  wire                        fifo_pop,
	output logic                       byte_credit,
	output logic                       fifo_valid,
	output predecode_pkg::byte_t       fifo_data
);

	import predecode_pkg::*;

	// a single entry buffer still needs one pointer bit
	localparam int ptr_w = (in_depth > 1) ? $clog2(in_depth) : 1;
	localparam int cnt_w = $clog2(in_depth + 1);

	byte_t mem [in_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic pop;

	// pointers wrap at in_depth so the depth need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(in_depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// the head byte is visible as soon as the count says it is there
	assign fifo_valid = (count != '0);
	assign fifo_data = mem[rd_ptr];
	// the window only asks while data is present but the guard keeps the count sane
	assign pop = fifo_pop && fifo_valid;

	// storage itself, the sender never writes without a credit so no full check here
	always_ff @(posedge clk) begin
		if (byte_valid)
			mem[wr_ptr] <= byte_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			byte_credit <= 1'b0;
		end else begin
			if (byte_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// write and pop in one cycle leave the occupancy unchanged
			count <= count + cnt_w'(byte_valid) - cnt_w'(pop);
			// each freed slot goes back to the sender one cycle after the pop
			byte_credit <= pop;
		end
	end

endmodule

`default_nettype wire

// ==== common/predecode_pkg.sv ====
// predecoder package with stream widths, length classes and 65xx opcode constants
`default_nettype none

package predecode_pkg;

	// ====================================================================
	// stream and instruction widths
	// ====================================================================

	typedef logic [7:0] byte_t;
	typedef logic [15:0] addr_t;
	// instruction length in bytes, 1 up to 4
	typedef logic [2:0] len_t;
	// program counter step handed to the execute stage
	typedef logic [3:0] pcinc_t;
	// operand bytes are little endian, first operand byte in bits 7:0
	typedef logic [23:0] operand_t;
	// window occupancy counts 0 to 4 so it is one bit wider than an index
	typedef logic [2:0] fill_t;

	// the longest instruction is an opcode plus three operand bytes
	localparam int window_depth = 4;

	// length classes
	localparam len_t len_implied = 3'd1;
	localparam len_t len_short = 3'd2;
	localparam len_t len_long = 3'd3;
	localparam len_t len_far = 3'd4;

	// ====================================================================
	// control flow opcodes
	// ====================================================================

	localparam byte_t op_brk = 8'h00;
	localparam byte_t op_bpl = 8'h10, op_bmi = 8'h30, op_bvc = 8'h50, op_bvs = 8'h70;
	localparam byte_t op_bcc = 8'h90, op_bcs = 8'hb0, op_bne = 8'hd0, op_beq = 8'hf0;
	localparam byte_t op_bra = 8'h80, op_brl = 8'h82;
	localparam byte_t op_jmp = 8'h4c, op_jml = 8'h5c, op_jsr = 8'h20, op_jsl = 8'h22;
	localparam byte_t op_rts = 8'h60, op_rti = 8'h40;

	// ====================================================================
	// single byte opcodes
	// ====================================================================

	localparam byte_t op_clc = 8'h18, op_sec = 8'h38, op_cli = 8'h58, op_sei = 8'h78;
	localparam byte_t op_clv = 8'hb8, op_cld = 8'hd8, op_sed = 8'hf8;
	localparam byte_t op_tax = 8'haa, op_txa = 8'h8a, op_tay = 8'ha8, op_tya = 8'h98;
	localparam byte_t op_tsx = 8'hba, op_txs = 8'h9a, op_txy = 8'h9b, op_tyx = 8'hbb;
	localparam byte_t op_nop = 8'hea;
	localparam byte_t op_asl_acc = 8'h0a, op_lsr_acc = 8'h4a;
	localparam byte_t op_rol_acc = 8'h2a, op_ror_acc = 8'h6a;
	localparam byte_t op_pha = 8'h48, op_pla = 8'h68, op_php = 8'h08, op_plp = 8'h28;
	localparam byte_t op_phx = 8'hda, op_plx = 8'hfa, op_phy = 8'h5a, op_ply = 8'h7a;

	// ====================================================================
	// accumulator group, in the order imm zp zpx ind indx indy abs absx absy
	// ====================================================================

	localparam byte_t op_adc_imm = 8'h69, op_adc_zp = 8'h65, op_adc_zpx = 8'h75;
	localparam byte_t op_adc_i = 8'h72, op_adc_ix = 8'h61, op_adc_iy = 8'h71;
	localparam byte_t op_adc_abs = 8'h6d, op_adc_absx = 8'h7d, op_adc_absy = 8'h79;
	localparam byte_t op_sbc_imm = 8'he9, op_sbc_zp = 8'he5, op_sbc_zpx = 8'hf5;
	localparam byte_t op_sbc_i = 8'hf2, op_sbc_ix = 8'he1, op_sbc_iy = 8'hf1;
	localparam byte_t op_sbc_abs = 8'hed, op_sbc_absx = 8'hfd, op_sbc_absy = 8'hf9;
	localparam byte_t op_cmp_imm = 8'hc9, op_cmp_zp = 8'hc5, op_cmp_zpx = 8'hd5;
	localparam byte_t op_cmp_i = 8'hd2, op_cmp_ix = 8'hc1, op_cmp_iy = 8'hd1;
	localparam byte_t op_cmp_abs = 8'hcd, op_cmp_absx = 8'hdd, op_cmp_absy = 8'hd9;
	localparam byte_t op_and_imm = 8'h29, op_and_zp = 8'h25, op_and_zpx = 8'h35;
	localparam byte_t op_and_i = 8'h32, op_and_ix = 8'h21, op_and_iy = 8'h31;
	localparam byte_t op_and_abs = 8'h2d, op_and_absx = 8'h3d, op_and_absy = 8'h39;
	localparam byte_t op_ora_imm = 8'h09, op_ora_zp = 8'h05, op_ora_zpx = 8'h15;
	localparam byte_t op_ora_i = 8'h12, op_ora_ix = 8'h01, op_ora_iy = 8'h11;
	localparam byte_t op_ora_abs = 8'h0d, op_ora_absx = 8'h1d, op_ora_absy = 8'h19;
	localparam byte_t op_eor_imm = 8'h49, op_eor_zp = 8'h45, op_eor_zpx = 8'h55;
	localparam byte_t op_eor_i = 8'h52, op_eor_ix = 8'h41, op_eor_iy = 8'h51;
	localparam byte_t op_eor_abs = 8'h4d, op_eor_absx = 8'h5d, op_eor_absy = 8'h59;
	localparam byte_t op_lda_imm = 8'ha9, op_lda_zp = 8'ha5, op_lda_zpx = 8'hb5;
	localparam byte_t op_lda_i = 8'hb2, op_lda_ix = 8'ha1, op_lda_iy = 8'hb1;
	localparam byte_t op_lda_abs = 8'had, op_lda_absx = 8'hbd, op_lda_absy = 8'hb9;
	// stores have no immediate form
	localparam byte_t op_sta_zp = 8'h85, op_sta_zpx = 8'h95;
	localparam byte_t op_sta_i = 8'h92, op_sta_ix = 8'h81, op_sta_iy = 8'h91;
	localparam byte_t op_sta_abs = 8'h8d, op_sta_absx = 8'h9d, op_sta_absy = 8'h99;

	// ====================================================================
	// index register loads
	// ====================================================================

	localparam byte_t op_ldx_imm = 8'ha2, op_ldx_zp = 8'ha6, op_ldx_zpy = 8'hb6;
	localparam byte_t op_ldx_abs = 8'hae, op_ldx_absy = 8'hbe;
	localparam byte_t op_ldy_imm = 8'ha0, op_ldy_zp = 8'ha4, op_ldy_zpx = 8'hb4;
	localparam byte_t op_ldy_abs = 8'hac, op_ldy_absx = 8'hbc;

endpackage

`default_nettype wire
